// ==== dcache_pkg.sv ====
package dcache_pkg;

    // cache geometry
    localparam int SET_COUNT = 8;
    localparam int WAY_COUNT = 4;

    typedef logic [31:0] addr_t;
    typedef logic [2:0]  set_idx_t;
    typedef logic [1:0]  way_idx_t;
    typedef logic [9:0]  tag_t;

    // tag 0 means no transaction
    typedef logic [3:0]  mem_tag_t;
    typedef logic [4:0]  load_id_t;

    typedef enum logic [1:0] {
        MEM_BYTE = 2'd0,
        MEM_HALF = 2'd1,
        MEM_WORD = 2'd2
    } mem_size_t;

    typedef enum logic [1:0] {
        BUS_NONE  = 2'd0,
        BUS_LOAD  = 2'd1,
        BUS_STORE = 2'd2
    } bus_command_t;

    // one 64-bit line seen at three access widths
    typedef union packed {
        logic [7:0][7:0]  bytes;
        logic [3:0][15:0] halves;
        logic [1:0][31:0] words;
    } cache_line_t;

    // address split: tag [15:6], set [5:3], byte [2:0]
    function automatic set_idx_t addr_set(input addr_t addr);
        return addr[5:3];
    endfunction

    function automatic tag_t addr_tag(input addr_t addr);
        return addr[15:6];
    endfunction

endpackage

// ==== tree_plru.sv ====
`timescale 1ns/1ps

module tree_plru import dcache_pkg::*; (
    input  logic     clock,
    input  logic     reset,
    input  logic     update,
    input  set_idx_t update_set,
    input  way_idx_t update_way,
    input  set_idx_t lookup_set,
    output way_idx_t victim_way
);

    // bit 0 root, bit 1 left pair, bit 2 right pair
    logic [SET_COUNT-1:0][2:0] tree_bits;
    logic [2:0]                lookup_bits;

    assign lookup_bits = tree_bits[lookup_set];

    // root picks the half, then the pair bit picks the way
    always_comb begin
        if (lookup_bits[0]) begin
            victim_way = lookup_bits[2] ? 2'd3 : 2'd2;
        end else begin
            victim_way = lookup_bits[1] ? 2'd1 : 2'd0;
        end
    end

    // point away from the accessed half and way
    always_ff @(posedge clock) begin
        if (reset) begin
            tree_bits <= '0;
        end else if (update) begin
            tree_bits[update_set][0] <= ~update_way[1];
            if (update_way[1]) begin
                tree_bits[update_set][2] <= ~update_way[0];
            end else begin
                tree_bits[update_set][1] <= ~update_way[0];
            end
        end
    end

endmodule

// ==== load_extract.sv ====
`timescale 1ns/1ps

module load_extract import dcache_pkg::*; (
    input  cache_line_t line,
    input  logic [2:0]  offset,
    input  mem_size_t   size,
    input  logic        signed_load,
    output logic [31:0] value
);

    logic [7:0]  picked_byte;
    logic [15:0] picked_half;
    logic [31:0] picked_word;

    assign picked_byte = line.bytes[offset];
    assign picked_half = line.halves[offset[2:1]];
    assign picked_word = line.words[offset[2]];

    always_comb begin
        case (size)
            MEM_BYTE: begin
                value = signed_load ? {{24{picked_byte[7]}}, picked_byte}
                                    : {24'b0, picked_byte};
            end
            MEM_HALF: begin
                value = signed_load ? {{16{picked_half[15]}}, picked_half}
                                    : {16'b0, picked_half};
            end
            default: begin
                value = picked_word;
            end
        endcase
    end

endmodule

// ==== dcache_array.sv ====
`timescale 1ns/1ps

module dcache_array import dcache_pkg::*; (
    input  logic        clock,
    input  logic        reset,

    input  addr_t       load_addr,
    output logic        load_hit,
    output way_idx_t    load_way,
    output cache_line_t load_line,

    input  logic        store_valid,
    input  addr_t       store_addr,
    input  mem_size_t   store_size,
    input  logic [31:0] store_data,
    output logic        store_hit,
    output way_idx_t    store_way,

    input  logic        fill_valid,
    input  addr_t       fill_addr,
    input  cache_line_t fill_line,
    input  way_idx_t    victim_way,
    output way_idx_t    fill_way
);

    tag_t        tags  [SET_COUNT][WAY_COUNT];
    cache_line_t lines [SET_COUNT][WAY_COUNT];
    logic [SET_COUNT-1:0][WAY_COUNT-1:0] valid;

    set_idx_t             load_set;
    set_idx_t             store_set;
    set_idx_t             fill_set;
    logic [WAY_COUNT-1:0] load_match;
    logic [WAY_COUNT-1:0] store_match;
    cache_line_t          store_merged;

    assign load_set  = addr_set(load_addr);
    assign store_set = addr_set(store_addr);
    assign fill_set  = addr_set(fill_addr);

    // tag compare across all ways
    always_comb begin
        for (int w = 0; w < WAY_COUNT; w++) begin
            load_match[w]  = valid[load_set][w] && (tags[load_set][w] == addr_tag(load_addr));
            store_match[w] = store_valid && valid[store_set][w]
                             && (tags[store_set][w] == addr_tag(store_addr));
        end
    end

    always_comb begin
        load_way  = '0;
        store_way = '0;
        for (int w = 0; w < WAY_COUNT; w++) begin
            if (load_match[w]) begin
                load_way = way_idx_t'(w);
            end
            if (store_match[w]) begin
                store_way = way_idx_t'(w);
            end
        end
    end

    assign load_hit  = |load_match;
    assign store_hit = |store_match;
    assign load_line = lines[load_set][load_way];

    // lowest invalid way wins, plru victim when the set is full
    always_comb begin
        fill_way = victim_way;
        for (int w = WAY_COUNT - 1; w >= 0; w--) begin
            if (!valid[fill_set][w]) begin
                fill_way = way_idx_t'(w);
            end
        end
    end

    // store data merged into the hit line
    always_comb begin
        store_merged = lines[store_set][store_way];
        case (store_size)
            MEM_BYTE: store_merged.bytes[store_addr[2:0]]  = store_data[7:0];
            MEM_HALF: store_merged.halves[store_addr[2:1]] = store_data[15:0];
            default:  store_merged.words[store_addr[2]]    = store_data;
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            valid <= '0;
        end else if (fill_valid) begin
            valid[fill_set][fill_way] <= 1'b1;
        end
    end

    // a fill into the store's way overwrites the merge
    always_ff @(posedge clock) begin
        if (store_hit) begin
            lines[store_set][store_way] <= store_merged;
        end
        if (fill_valid) begin
            lines[fill_set][fill_way] <= fill_line;
            tags[fill_set][fill_way]  <= addr_tag(fill_addr);
        end
    end

    a_single_match: assert property (@(posedge clock) disable iff (reset)
        $onehot0(load_match) && $onehot0(store_match))
        else $error("more than one way matches a lookup");

endmodule

// ==== miss_buffer.sv ====
`timescale 1ns/1ps

module miss_buffer import dcache_pkg::*; #(
    parameter int MISS_DEPTH = 4
) (
    input  logic        clock,
    input  logic        reset,
    input  logic        flush,

    input  logic        enqueue,
    input  addr_t       load_addr,
    input  mem_size_t   load_size,
    input  logic        load_signed,
    input  load_id_t    load_id,
    output logic        load_ready,

    output logic        issue_valid,
    output addr_t       issue_addr,
    input  logic        issue_blocked,
    input  mem_tag_t    mem_response,

    input  mem_tag_t    mem_tag,
    input  cache_line_t mem_rdata,

    output logic        head_done,
    output addr_t       head_addr,
    output mem_size_t   head_size,
    output logic        head_signed,
    output load_id_t    head_id,
    output cache_line_t head_line,
    input  logic        retire
);

    localparam int PTR_W = (MISS_DEPTH > 1) ? $clog2(MISS_DEPTH) : 1;

    logic [PTR_W-1:0] head_ptr;
    logic [PTR_W-1:0] send_ptr;
    logic [PTR_W-1:0] tail_ptr;

    // per-entry state
    logic [MISS_DEPTH-1:0] entry_valid;
    logic [MISS_DEPTH-1:0] entry_sent;
    logic [MISS_DEPTH-1:0] entry_done;
    logic [MISS_DEPTH-1:0] capture;

    // per-entry payload
    addr_t       entry_addr   [MISS_DEPTH];
    mem_size_t   entry_size   [MISS_DEPTH];
    logic        entry_signed [MISS_DEPTH];
    load_id_t    entry_id     [MISS_DEPTH];
    mem_tag_t    entry_tag    [MISS_DEPTH];
    cache_line_t entry_line   [MISS_DEPTH];

    logic accept;

    function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(MISS_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    // full once the tail slot is still occupied
    assign load_ready  = !entry_valid[tail_ptr];

    assign issue_valid = entry_valid[send_ptr] && !entry_sent[send_ptr];
    assign issue_addr  = entry_addr[send_ptr];
    assign accept      = issue_valid && !issue_blocked && (mem_response != '0);

    // returning data matched against every outstanding tag
    always_comb begin
        for (int i = 0; i < MISS_DEPTH; i++) begin
            capture[i] = entry_valid[i] && entry_sent[i] && !entry_done[i]
                         && (mem_tag != '0) && (entry_tag[i] == mem_tag);
        end
    end

    assign head_done   = entry_valid[head_ptr] && entry_done[head_ptr];
    assign head_addr   = entry_addr[head_ptr];
    assign head_size   = entry_size[head_ptr];
    assign head_signed = entry_signed[head_ptr];
    assign head_id     = entry_id[head_ptr];
    assign head_line   = entry_line[head_ptr];

    always_ff @(posedge clock) begin
        if (reset || flush) begin
            entry_valid <= '0;
            entry_sent  <= '0;
            entry_done  <= '0;
            head_ptr    <= '0;
            send_ptr    <= '0;
            tail_ptr    <= '0;
        end else begin
            if (enqueue) begin
                entry_valid[tail_ptr] <= 1'b1;
                entry_sent[tail_ptr]  <= 1'b0;
                entry_done[tail_ptr]  <= 1'b0;
                tail_ptr              <= ptr_next(tail_ptr);
            end
            // refused reads stay at the send pointer
            if (accept) begin
                entry_sent[send_ptr] <= 1'b1;
                send_ptr             <= ptr_next(send_ptr);
            end
            for (int i = 0; i < MISS_DEPTH; i++) begin
                if (capture[i]) begin
                    entry_done[i] <= 1'b1;
                end
            end
            if (retire) begin
                entry_valid[head_ptr] <= 1'b0;
                head_ptr              <= ptr_next(head_ptr);
            end
        end
    end

    always_ff @(posedge clock) begin
        if (enqueue) begin
            entry_addr[tail_ptr]   <= load_addr;
            entry_size[tail_ptr]   <= load_size;
            entry_signed[tail_ptr] <= load_signed;
            entry_id[tail_ptr]     <= load_id;
        end
        if (accept) begin
            entry_tag[send_ptr] <= mem_response;
        end
        for (int i = 0; i < MISS_DEPTH; i++) begin
            if (capture[i]) begin
                entry_line[i] <= mem_rdata;
            end
        end
    end

    a_no_enqueue_full: assert property (@(posedge clock) disable iff (reset)
        enqueue |-> load_ready)
        else $error("miss enqueued while the buffer is full");

    a_retire_done: assert property (@(posedge clock) disable iff (reset)
        retire |-> head_done)
        else $error("retire without data at the head");

endmodule

// ==== dcache.sv ====
`timescale 1ns/1ps

module dcache import dcache_pkg::*; #(
    parameter int MISS_DEPTH = 4
) (
    input  logic         clock,
    input  logic         reset,

    input  logic         load_valid,
    input  addr_t        load_addr,
    input  mem_size_t    load_size,
    input  logic         load_signed,
    input  load_id_t     load_id,
    output logic         load_ready,

    input  logic         store_valid,
    input  addr_t        store_addr,
    input  mem_size_t    store_size,
    input  logic [31:0]  store_data,

    input  logic         flush,

    output bus_command_t mem_command,
    output addr_t        mem_addr,
    output mem_size_t    mem_size,
    output logic [31:0]  mem_wdata,
    input  mem_tag_t     mem_response,
    input  mem_tag_t     mem_tag,
    input  cache_line_t  mem_rdata,

    output logic         result_valid,
    output logic [31:0]  result_value,
    output load_id_t     result_id
);

    logic        array_load_hit;
    logic        load_hit;
    way_idx_t    load_way;
    cache_line_t load_line;
    logic        store_hit;
    way_idx_t    store_way;
    way_idx_t    fill_way;
    way_idx_t    victim_way;

    logic        enqueue;
    logic        issue_valid;
    addr_t       issue_addr;
    logic        issue_blocked;
    logic        read_out;
    mem_tag_t    read_response;

    logic        head_done;
    addr_t       head_addr;
    mem_size_t   head_size;
    logic        head_signed;
    load_id_t    head_id;
    cache_line_t head_line;
    logic        head_result;
    logic        retire;

    logic [31:0] hit_value;
    logic [31:0] miss_value;

    logic        plru_update;
    set_idx_t    plru_set;
    way_idx_t    plru_way;

    assign load_hit = load_valid && array_load_hit;
    assign enqueue  = load_valid && !array_load_hit && !flush;

    // the head waits a cycle behind a same-cycle hit
    assign head_result = head_done && !flush;
    assign retire      = head_result && !load_hit;

    assign result_valid = load_hit || head_result;
    assign result_value = load_hit ? hit_value : miss_value;
    assign result_id    = load_hit ? load_id : head_id;

    // stores own the bus, reads go out otherwise
    assign issue_blocked = store_valid || flush;
    assign read_out      = issue_valid && !issue_blocked;
    assign read_response = read_out ? mem_response : '0;

    assign mem_command = store_valid ? BUS_STORE : (read_out ? BUS_LOAD : BUS_NONE);
    assign mem_addr    = store_valid ? store_addr : {issue_addr[31:3], 3'b000};
    assign mem_size    = store_valid ? store_size : MEM_WORD;
    assign mem_wdata   = store_valid ? store_data : '0;

    // load hit first, then the fill, then a store hit
    assign plru_update = load_hit || retire || store_hit;
    assign plru_set    = load_hit ? addr_set(load_addr)
                       : (retire ? addr_set(head_addr) : addr_set(store_addr));
    assign plru_way    = load_hit ? load_way : (retire ? fill_way : store_way);

    dcache_array u_array (
        .clock       (clock),
        .reset       (reset),
        .load_addr   (load_addr),
        .load_hit    (array_load_hit),
        .load_way    (load_way),
        .load_line   (load_line),
        .store_valid (store_valid),
        .store_addr  (store_addr),
        .store_size  (store_size),
        .store_data  (store_data),
        .store_hit   (store_hit),
        .store_way   (store_way),
        .fill_valid  (retire),
        .fill_addr   (head_addr),
        .fill_line   (head_line),
        .victim_way  (victim_way),
        .fill_way    (fill_way)
    );

    miss_buffer #(
        .MISS_DEPTH (MISS_DEPTH)
    ) u_miss_buffer (
        .clock         (clock),
        .reset         (reset),
        .flush         (flush),
        .enqueue       (enqueue),
        .load_addr     (load_addr),
        .load_size     (load_size),
        .load_signed   (load_signed),
        .load_id       (load_id),
        .load_ready    (load_ready),
        .issue_valid   (issue_valid),
        .issue_addr    (issue_addr),
        .issue_blocked (issue_blocked),
        .mem_response  (read_response),
        .mem_tag       (mem_tag),
        .mem_rdata     (mem_rdata),
        .head_done     (head_done),
        .head_addr     (head_addr),
        .head_size     (head_size),
        .head_signed   (head_signed),
        .head_id       (head_id),
        .head_line     (head_line),
        .retire        (retire)
    );

    tree_plru u_plru (
        .clock      (clock),
        .reset      (reset),
        .update     (plru_update),
        .update_set (plru_set),
        .update_way (plru_way),
        .lookup_set (addr_set(head_addr)),
        .victim_way (victim_way)
    );

    load_extract u_hit_extract (
        .line        (load_line),
        .offset      (load_addr[2:0]),
        .size        (load_size),
        .signed_load (load_signed),
        .value       (hit_value)
    );

    load_extract u_miss_extract (
        .line        (head_line),
        .offset      (head_addr[2:0]),
        .size        (head_size),
        .signed_load (head_signed),
        .value       (miss_value)
    );

endmodule

// ==== tb_dcache.sv ====
`timescale 1ns/1ps

module tb_dcache import dcache_pkg::*; ();

    localparam int MISS_DEPTH = 4;

    logic         clock;
    logic         reset;
    logic         load_valid;
    addr_t        load_addr;
    mem_size_t    load_size;
    logic         load_signed;
    load_id_t     load_id;
    logic         load_ready;
    logic         store_valid;
    addr_t        store_addr;
    mem_size_t    store_size;
    logic [31:0]  store_data;
    logic         flush;
    bus_command_t mem_command;
    addr_t        mem_addr;
    mem_size_t    mem_size;
    logic [31:0]  mem_wdata;
    mem_tag_t     mem_response;
    mem_tag_t     mem_tag;
    cache_line_t  mem_rdata;
    logic         result_valid;
    logic [31:0]  result_value;
    load_id_t     result_id;

    // scoreboard, indexed by load id
    logic        pending      [32];
    logic [31:0] exp_value    [32];
    logic        exp_miss     [32];
    addr_t       exp_line     [32];
    int          accept_count [32];
    string       id_name      [32];

    // memory model: written bytes, pattern elsewhere
    logic [7:0]  written [addr_t];
    int          ret_due  [$];
    mem_tag_t    ret_tag  [$];
    addr_t       ret_addr [$];
    logic [31:0] lcg_state;
    logic        refuse_now;
    mem_tag_t    next_tag;
    logic        tag_taken;
    int          cycle;

    int errors;
    int checks;
    int limit_cycles;

    dcache #(.MISS_DEPTH(MISS_DEPTH)) u_dut (.*);

    function automatic logic [31:0] lcg_step(input logic [31:0] state);
        return state * 32'd1103515245 + 32'd12345;
    endfunction

    function automatic logic [7:0] mem_byte(input addr_t a);
        logic [31:0] product;
        if (written.exists(a)) begin
            return written[a];
        end
        product = a * 32'd7 + 32'd3;
        // upper address bytes folded in so every address bit counts
        return product[7:0] ^ a[15:8] ^ a[23:16] ^ a[31:24];
    endfunction

    function automatic cache_line_t line_from_memory(input addr_t a);
        cache_line_t line;
        for (int i = 0; i < 8; i++) begin
            line.bytes[i] = mem_byte({a[31:3], 3'(i)});
        end
        return line;
    endfunction

    function automatic int outstanding();
        int count;
        count = 0;
        for (int i = 0; i < 32; i++) begin
            if (pending[i]) begin
                count++;
            end
        end
        return count;
    endfunction

    // misses already sitting in the buffer, the one being requested now excluded
    function automatic int buffered_misses();
        int count;
        count = 0;
        for (int i = 0; i < 32; i++) begin
            if (pending[i] && exp_miss[i] && !(load_valid && load_id_t'(i) == load_id)) begin
                count++;
            end
        end
        return count;
    endfunction

    task automatic write_memory(input addr_t a, input mem_size_t size, input logic [31:0] data);
        int bytes;
        bytes = (size == MEM_BYTE) ? 1 : ((size == MEM_HALF) ? 2 : 4);
        for (int i = 0; i < bytes; i++) begin
            written[a + addr_t'(i)] = data[8*i +: 8];
        end
    endtask

    task automatic compare_value(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
        checks++;
        assert (expected === actual) else begin
            errors++;
            $display("MISMATCH %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic wait_drained();
        while (outstanding() != 0) begin
            @(posedge clock);
        end
        #1;
    endtask

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    always @(posedge clock) begin
        cycle <= cycle + 1;
    end

    assign mem_response = (mem_command == BUS_LOAD && !refuse_now) ? next_tag : 4'd0;

    // refusal draw, tag rotation and read data return, just after the edge
    always @(posedge clock) begin
        #1;
        lcg_state = lcg_step(lcg_state);
        refuse_now = (lcg_state[31:30] == 2'b00);
        if (tag_taken) begin
            next_tag = (next_tag == 4'd15) ? 4'd1 : next_tag + 4'd1;
            tag_taken = 1'b0;
        end
        if (ret_due.size() != 0 && ret_due[0] <= cycle) begin
            mem_tag   = ret_tag.pop_front();
            mem_rdata = line_from_memory(ret_addr.pop_front());
            void'(ret_due.pop_front());
        end else begin
            mem_tag   = '0;
            mem_rdata = '0;
        end
    end

    // monitor samples mid-cycle
    always @(negedge clock) begin
        if (!reset) begin
            // buffer is full once every slot holds a miss
            compare_value("load ready", (buffered_misses() < MISS_DEPTH) ? 32'd1 : 32'd0,
                          32'(load_ready));
            if (result_valid) begin
                checks++;
                assert (pending[result_id]) else begin
                    errors++;
                    $display("result for load id %0d that has no load outstanding", result_id);
                end
                if (pending[result_id]) begin
                    compare_value(id_name[result_id], exp_value[result_id], result_value);
                    compare_value({id_name[result_id], " bus loads"},
                                  exp_miss[result_id] ? 32'd1 : 32'd0,
                                  32'(accept_count[result_id]));
                    pending[result_id] = 1'b0;
                end
            end
            if (load_valid && !exp_miss[load_id]) begin
                checks++;
                assert (result_valid && result_id == load_id) else begin
                    errors++;
                    $display("load id %0d should hit but gave no same-cycle result", load_id);
                end
            end
            if (mem_command == BUS_LOAD && mem_response != '0) begin
                int owner;
                owner = -1;
                for (int i = 0; i < 32; i++) begin
                    if (pending[i] && exp_line[i] == mem_addr) begin
                        owner = i;
                    end
                end
                checks++;
                assert (owner >= 0) else begin
                    errors++;
                    $display("bus load to %h with no miss outstanding for that line", mem_addr);
                end
                if (owner >= 0) begin
                    accept_count[owner]++;
                end
                ret_due.push_back(cycle + 3);
                ret_tag.push_back(mem_response);
                ret_addr.push_back(mem_addr);
                tag_taken = 1'b1;
            end
            if (store_valid) begin
                compare_value("store command", 32'(BUS_STORE), 32'(mem_command));
                compare_value("store address", store_addr, mem_addr);
                compare_value("store size", 32'(store_size), 32'(mem_size));
                compare_value("store data", store_data, mem_wdata);
                write_memory(store_addr, store_size, store_data);
            end else begin
                checks++;
                assert (mem_command != BUS_STORE) else begin
                    errors++;
                    $display("store command on the bus with no store requested");
                end
            end
            if (flush) begin
                for (int i = 0; i < 32; i++) begin
                    pending[i] = 1'b0;
                end
            end
        end
    end

    initial begin
        wait (limit_cycles != 0);
        repeat (limit_cycles) @(posedge clock);
        $display("timeout: run did not finish within %0d cycles", limit_cycles);
        $display("=== FAIL ===");
        $finish;
    end

    initial begin
        int          fd;
        int          code;
        int          line_no;
        int          total_lines;
        logic [7:0]  op;
        string       rest;
        addr_t       f_addr;
        int          f_size;
        int          f_signed;
        logic [31:0] f_data;
        logic [31:0] f_expected;
        int          f_miss;
        load_id_t    id;

        reset = 1'b1;
        load_valid = 1'b0;
        load_addr = '0;
        load_size = MEM_BYTE;
        load_signed = 1'b0;
        load_id = '0;
        store_valid = 1'b0;
        store_addr = '0;
        store_size = MEM_BYTE;
        store_data = '0;
        flush = 1'b0;
        mem_tag = '0;
        mem_rdata = '0;
        lcg_state = 32'd51;
        refuse_now = 1'b0;
        next_tag = 4'd1;
        tag_taken = 1'b0;
        cycle = 0;
        errors = 0;
        checks = 0;
        line_no = 0;
        total_lines = 0;
        for (int i = 0; i < 32; i++) begin
            pending[i] = 1'b0;
            exp_miss[i] = 1'b0;
        end

        fd = $fopen("tb_dcache_input.txt", "r");
        if (fd == 0) begin
            $display("cannot open tb_dcache_input.txt");
            $display("=== FAIL ===");
            $finish;
        end else begin
            while ($fgets(rest, fd) != 0) begin
                total_lines++;
            end
            $fclose(fd);
            fd = $fopen("tb_dcache_input.txt", "r");
            limit_cycles = total_lines * 40 + 20;

            repeat (2) @(posedge clock);
            #1;
            reset = 1'b0;

            forever begin
                code = $fscanf(fd, " %c", op);
                if (code != 1) begin
                    break;
                end
                line_no++;
                if (op == "#") begin
                    code = $fgets(rest, fd);
                    continue;
                end
                code = $fscanf(fd, "%h %d %d %h %h %d", f_addr, f_size, f_signed, f_data,
                               f_expected, f_miss);
                @(posedge clock);
                #1;
                load_valid = 1'b0;
                store_valid = 1'b0;
                flush = 1'b0;
                case (op)
                    "L": begin
                        while (!load_ready) begin
                            @(posedge clock);
                            #1;
                        end
                        id = f_data[4:0];
                        pending[id] = 1'b1;
                        exp_value[id] = f_expected;
                        exp_miss[id] = (f_miss != 0);
                        exp_line[id] = {f_addr[31:3], 3'b000};
                        accept_count[id] = 0;
                        id_name[id] = $sformatf("line %0d load id %0d", line_no, id);
                        load_valid = 1'b1;
                        load_addr = f_addr;
                        load_size = mem_size_t'(f_size[1:0]);
                        load_signed = (f_signed != 0);
                        load_id = id;
                    end
                    "S": begin
                        store_valid = 1'b1;
                        store_addr = f_addr;
                        store_size = mem_size_t'(f_size[1:0]);
                        store_data = f_data;
                    end
                    "F": begin
                        flush = 1'b1;
                    end
                    default: begin
                        // wait the given cycles, then until all loads are back
                        repeat (int'(f_addr)) @(posedge clock);
                        wait_drained();
                    end
                endcase
            end
            $fclose(fd);

            @(posedge clock);
            #1;
            load_valid = 1'b0;
            store_valid = 1'b0;
            flush = 1'b0;
            wait_drained();
            // catch stray results after the last load
            repeat (6) @(posedge clock);

            $display("checks: %0d, errors: %0d", checks, errors);
            if (errors == 0) begin
                $display("=== PASS ===");
            end else begin
                $display("=== FAIL ===");
            end
            $finish;
        end
    end

endmodule

// ==== tb_dcache_input.txt ====
# op addr size(0 byte 1 half 2 word) signed id_or_store_data expected expect_miss, hex except size/signed/miss
# W waits addr cycles then until all loads return; F flushes; unused columns are 0
L 00000000 2 0 01 18110a03 1
L 00000013 0 1 02 ffffff88 1
L 00000022 1 0 03 0000f8f1 1
W 00000014 0 0 00 00000000 0
L 00000013 0 0 04 00000088 0
L 00000022 1 1 05 fffff8f1 0
L 00000004 2 0 06 342d261f 0
L 00000030 0 0 07 00000053 1
L 00000038 1 1 08 ffff928b 1
L 0000001c 2 0 09 dcd5cec7 1
L 0000002e 1 0 0a 00004c45 1
W 00000014 0 0 00 00000000 0
S 00000004 2 0 cafef00d 00000000 0
L 00000004 2 0 0b cafef00d 0
S 00000013 0 0 0000005a 00000000 0
L 00000012 1 0 0c 00005a81 0
S 0000003a 1 0 0000beef 00000000 0
L 00000038 2 0 0d beef928b 0
S 00000050 2 0 12345678 00000000 0
L 00000052 1 1 0e 00001234 1
W 00000014 0 0 00 00000000 0
L 00000008 0 0 0f 0000003b 1
L 00000048 0 1 10 fffffffb 1
L 00000088 0 0 11 000000bb 1
L 000000c8 0 1 12 0000007b 1
W 00000014 0 0 00 00000000 0
L 00000108 0 0 13 0000003a 1
W 00000014 0 0 00 00000000 0
L 0000010c 2 0 14 6d645f56 0
L 0000004c 2 0 15 2c251e17 0
L 0000000c 2 0 16 6c655e57 1
W 00000014 0 0 00 00000000 0
L 00000040 0 0 17 000000c3 1
L 00000060 1 1 18 ffffaaa3 1
F 00000000 0 0 00 00000000 0
W 0000000a 0 0 00 00000000 0
L 00000040 0 0 19 000000c3 1
L 00000060 1 1 1a ffffaaa3 1
W 00000014 0 0 00 00000000 0
L 00000041 0 1 1b ffffffca 0
L 00000062 0 0 1c 000000b1 0
W 00000005 0 0 00 00000000 0

// ==== vlog.f ====
dcache_pkg.sv
tree_plru.sv
load_extract.sv
dcache_array.sv
miss_buffer.sv
dcache.sv
tb_dcache.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_dcache
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, check the log for the pass line"
	@echo "  clean  remove build output and log"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q '^=== PASS ===$$' $(LOG) || (echo "simulation failed" && exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
